//--- hdl/reorder_params.svh
`ifndef REORDER_PARAMS_SVH
`define REORDER_PARAMS_SVH

// width of a physical address on the coherent port
`define ECI_ADDR_WIDTH 40

// one cache line of data per beat
`define ECI_CL_WIDTH 1024

// line addresses step by this many bytes
`define ECI_CL_BYTES 128

// thread IDs in flight, also the reorder buffer depth
`define N_THREADS 32

// address bit that picks the virtual channel, so lines alternate
`define VC_SEL_BIT 7

`endif

//--- hdl/reorder_pkg.sv
`default_nettype none

`include "reorder_params.svh"

package reorder_pkg;

    typedef logic [$clog2(`N_THREADS)-1:0] thread_id_t;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // arlen counts lines minus one, start address is line aligned
    typedef struct packed {
        logic [`ECI_ADDR_WIDTH-1:0] araddr;
        logic [7:0]                 arlen;
    } rd_burst_t;

    typedef struct packed {
        logic [`ECI_ADDR_WIDTH-1:0] addr;
        logic                       last;
    } rd_line_t;

    typedef struct packed {
        logic [`ECI_ADDR_WIDTH-1:0] addr;
        thread_id_t                 id;
    } vc_req_t;

    typedef struct packed {
        logic [`ECI_CL_WIDTH-1:0] data;
        thread_id_t               id;
    } vc_rsp_t;

    typedef struct packed {
        logic [`ECI_CL_WIDTH-1:0] rdata;
        logic [1:0]               rresp;
        logic                     rlast;
    } rd_rsp_t;

    // entry of the issue order queue
    typedef struct packed {
        thread_id_t id;
        logic       last;
    } ord_entry_t;

    typedef struct packed {
        logic [2:0] arsize;
        logic [1:0] arburst;
        logic       arlock;
        logic [3:0] arcache;
        logic [2:0] arprot;
    } ar_attr_t;

endpackage

`default_nettype wire

//--- hdl/stage_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module stage_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  wire      aclk,
    input  wire      rst_n,

    input  wire      payload_t in_data,
    input  wire      in_valid,
    output logic     in_ready,

    output payload_t out_data,
    output logic     out_valid,
    input  wire      out_ready
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // nothing may be pushed into a full queue
    a_no_push_full: assert property (@(posedge aclk) disable iff (!rst_n)
        in_valid |-> in_ready)
        else $error("stage_fifo written while full");

endmodule

`default_nettype wire

//--- hdl/rd_burst_split.sv
`timescale 1ns/100ps
`default_nettype none

`include "reorder_params.svh"

module rd_burst_split (
    input  wire                    aclk,
    input  wire                    rst_n,

    input  wire reorder_pkg::rd_burst_t burst,
    input  wire                    ar_valid,
    output logic                   ar_ready,

    output reorder_pkg::rd_line_t  line,
    output logic                   line_valid,
    input  wire                    line_ready
);

    localparam int LINE_OFFSET = $clog2(`ECI_CL_BYTES);

    logic                       busy;
    logic [`ECI_ADDR_WIDTH-1:0] cur_addr;
    logic [7:0]                 remaining;
    logic                       accept;
    logic                       step;

    // a new burst is only taken once the previous one has drained
    assign ar_ready   = !busy;
    assign accept     = ar_valid && ar_ready;
    assign line_valid = busy;
    assign step       = line_valid && line_ready;

    assign line.addr = cur_addr;
    assign line.last = (remaining == 8'd0);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (step && line.last) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            cur_addr  <= burst.araddr;
            remaining <= burst.arlen;
        end else if (step && !line.last) begin
            cur_addr  <= cur_addr + `ECI_ADDR_WIDTH'(`ECI_CL_BYTES);
            remaining <= remaining - 8'd1;
        end
    end

    // the master must issue line aligned bursts
    a_line_aligned: assert property (@(posedge aclk) disable iff (!rst_n)
        accept |-> (burst.araddr[LINE_OFFSET-1:0] == '0))
        else $error("burst address %h is not line aligned", burst.araddr);

endmodule

`default_nettype wire

//--- hdl/rd_vc_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

`include "reorder_params.svh"

module rd_vc_dispatch (
    input  wire                       aclk,
    input  wire                       rst_n,

    input  wire reorder_pkg::rd_line_t line,
    input  wire                       line_valid,
    output logic                      line_ready,

    output reorder_pkg::vc_req_t      vc_req [2],
    output logic [1:0]                req_valid,
    input  wire  [1:0]                req_ready,

    output logic                      ord_push,
    output reorder_pkg::thread_id_t   ord_id,
    output logic                      ord_last,

    input  wire                       release_valid,
    input  wire reorder_pkg::thread_id_t release_id
);

    import reorder_pkg::*;

    localparam int VC_FIFO_DEPTH = 4;

    logic [`N_THREADS-1:0] in_use;
    thread_id_t            free_id;
    logic                  id_avail;
    logic                  vc_sel;
    logic [1:0]            fifo_ready;
    logic                  take;
    vc_req_t               fifo_in;

    // lowest free ID wins
    always_comb begin
        free_id  = '0;
        id_avail = 1'b0;
        for (int i = `N_THREADS - 1; i >= 0; i--) begin
            if (!in_use[i]) begin
                free_id  = thread_id_t'(i);
                id_avail = 1'b1;
            end
        end
    end

    assign vc_sel     = line.addr[`VC_SEL_BIT];
    assign line_ready = id_avail && fifo_ready[vc_sel];
    assign take       = line_valid && line_ready;

    assign fifo_in.addr = line.addr;
    assign fifo_in.id   = free_id;

    assign ord_push = take;
    assign ord_id   = free_id;
    assign ord_last = line.last;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            in_use <= '0;
        end else begin
            if (release_valid) begin
                in_use[release_id] <= 1'b0;
            end
            if (take) begin
                in_use[free_id] <= 1'b1;
            end
        end
    end

    for (genvar i = 0; i < 2; i++) begin : g_vc
        stage_fifo #(
            .payload_t(vc_req_t),
            .DEPTH    (VC_FIFO_DEPTH)
        ) i_vc_fifo (
            .aclk     (aclk),
            .rst_n    (rst_n),
            .in_data  (fifo_in),
            .in_valid (take && (vc_sel == 1'(i))),
            .in_ready (fifo_ready[i]),
            .out_data (vc_req[i]),
            .out_valid(req_valid[i]),
            .out_ready(req_ready[i])
        );
    end

    // the reorder buffer only hands back IDs that were allocated here
    a_release_in_use: assert property (@(posedge aclk) disable iff (!rst_n)
        release_valid |-> in_use[release_id])
        else $error("released thread ID %0d was not in use", release_id);

endmodule

`default_nettype wire

//--- hdl/rd_reorder_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "reorder_params.svh"

module rd_reorder_buffer (
    input  wire                       aclk,
    input  wire                       rst_n,

    input  wire reorder_pkg::vc_rsp_t vc_rsp [2],
    input  wire  [1:0]                rsp_valid,
    output logic [1:0]                rsp_ready,

    input  wire                       ord_push,
    input  wire reorder_pkg::thread_id_t ord_id,
    input  wire                       ord_last,

    output reorder_pkg::rd_rsp_t      rsp,
    output logic                      r_valid,
    input  wire                       r_ready,

    output logic                      release_valid,
    output reorder_pkg::thread_id_t   release_id
);

    import reorder_pkg::*;

    logic [`ECI_CL_WIDTH-1:0] data_ram [`N_THREADS];
    logic [`N_THREADS-1:0]    filled;
    ord_entry_t               ord_in;
    ord_entry_t               head;
    logic                     head_valid;
    logic                     beat;

    // every ID in flight owns a slot, so responses are never stalled
    assign rsp_ready = 2'b11;

    assign ord_in.id   = ord_id;
    assign ord_in.last = ord_last;

    // the queue cannot overflow since it is as deep as the ID pool
    stage_fifo #(
        .payload_t(ord_entry_t),
        .DEPTH    (`N_THREADS)
    ) i_ord_fifo (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .in_data  (ord_in),
        .in_valid (ord_push),
        .in_ready (),
        .out_data (head),
        .out_valid(head_valid),
        .out_ready(beat)
    );

    always_ff @(posedge aclk) begin
        for (int i = 0; i < 2; i++) begin
            if (rsp_valid[i]) begin
                data_ram[vc_rsp[i].id] <= vc_rsp[i].data;
            end
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            filled <= '0;
        end else begin
            if (beat) begin
                filled[head.id] <= 1'b0;
            end
            for (int i = 0; i < 2; i++) begin
                if (rsp_valid[i]) begin
                    filled[vc_rsp[i].id] <= 1'b1;
                end
            end
        end
    end

    // head of the order queue leaves once its data has arrived
    assign r_valid   = head_valid && filled[head.id];
    assign beat      = r_valid && r_ready;
    assign rsp.rdata = data_ram[head.id];
    assign rsp.rresp = RESP_OKAY;
    assign rsp.rlast = head.last;

    assign release_valid = beat;
    assign release_id    = head.id;

    for (genvar i = 0; i < 2; i++) begin : g_chk
        a_slot_free: assert property (@(posedge aclk) disable iff (!rst_n)
            rsp_valid[i] |-> !filled[vc_rsp[i].id])
            else $error("channel %0d response overwrites slot %0d", i, vc_rsp[i].id);
    end

endmodule

`default_nettype wire

//--- hdl/eci_reorder_rd_2vc.sv
`timescale 1ns/100ps
`default_nettype none

`include "reorder_params.svh"

module eci_reorder_rd_2vc (
    input  wire                                  aclk,
    input  wire                                  rst_n,

    // upstream master
    input  wire reorder_pkg::rd_burst_t          ar_burst,
    input  wire                                  ar_valid,
    output logic                                 ar_ready,

    output reorder_pkg::rd_rsp_t                 r_rsp,
    output logic                                 r_valid,
    input  wire                                  r_ready,

    // virtual channels
    output logic [1:0][`ECI_ADDR_WIDTH-1:0]      ch_araddr,
    output reorder_pkg::thread_id_t [1:0]        ch_arid,
    output logic [1:0]                           ch_arvalid,
    input  wire  [1:0]                           ch_arready,

    input  wire  [1:0][`ECI_CL_WIDTH-1:0]        ch_rdata,
    input  wire reorder_pkg::thread_id_t [1:0]   ch_rid,
    input  wire  [1:0]                           ch_rvalid,
    output logic [1:0]                           ch_rready
);

    import reorder_pkg::*;

    // 128 byte INCR single line reads, normal access, data, non-secure
    localparam ar_attr_t AR_ATTR = '{
        arsize:  3'b111,
        arburst: 2'b01,
        arlock:  1'b0,
        arcache: 4'b0011,
        arprot:  3'b010
    };

    if (AR_ATTR.arsize != 3'($clog2(`ECI_CL_BYTES))) begin : g_attr_check
        $error("channel arsize does not cover one cache line");
    end

    rd_line_t   line;
    logic       line_valid;
    logic       line_ready;
    vc_req_t    vc_req [2];
    vc_rsp_t    vc_rsp [2];
    logic       ord_push;
    thread_id_t ord_id;
    logic       ord_last;
    logic       release_valid;
    thread_id_t release_id;

    for (genvar i = 0; i < 2; i++) begin : g_ch
        assign ch_araddr[i]   = vc_req[i].addr;
        assign ch_arid[i]     = vc_req[i].id;
        assign vc_rsp[i].data = ch_rdata[i];
        assign vc_rsp[i].id   = ch_rid[i];
    end

    rd_burst_split i_rd_burst_split (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .burst     (ar_burst),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .line      (line),
        .line_valid(line_valid),
        .line_ready(line_ready)
    );

    rd_vc_dispatch i_rd_vc_dispatch (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .line         (line),
        .line_valid   (line_valid),
        .line_ready   (line_ready),
        .vc_req       (vc_req),
        .req_valid    (ch_arvalid),
        .req_ready    (ch_arready),
        .ord_push     (ord_push),
        .ord_id       (ord_id),
        .ord_last     (ord_last),
        .release_valid(release_valid),
        .release_id   (release_id)
    );

    rd_reorder_buffer i_rd_reorder_buffer (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .vc_rsp       (vc_rsp),
        .rsp_valid    (ch_rvalid),
        .rsp_ready    (ch_rready),
        .ord_push     (ord_push),
        .ord_id       (ord_id),
        .ord_last     (ord_last),
        .rsp          (r_rsp),
        .r_valid      (r_valid),
        .r_ready      (r_ready),
        .release_valid(release_valid),
        .release_id   (release_id)
    );

endmodule

`default_nettype wire

//--- testbench/tb_mem_channel.sv
`timescale 1ns/100ps
`default_nettype none

`include "reorder_params.svh"

module tb_mem_channel #(
    parameter int unsigned SEED        = 60790,
    parameter int          CH          = 0,
    parameter int          MAX_PENDING = 8
) (
    input  wire                          aclk,
    input  wire                          rst_n,
    input  wire  [`ECI_ADDR_WIDTH-1:0]   araddr,
    input  wire reorder_pkg::thread_id_t arid,
    input  wire                          arvalid,
    output logic                         arready = 1'b0,
    output logic [`ECI_CL_WIDTH-1:0]     rdata = '0,
    output reorder_pkg::thread_id_t      rid = '0,
    output logic                         rvalid = 1'b0,
    input  wire                          rready
);

    import reorder_pkg::*;

    localparam int LINE_REPS = (`ECI_CL_WIDTH + `ECI_ADDR_WIDTH - 1) / `ECI_ADDR_WIDTH;

    typedef struct packed {
        logic [`ECI_ADDR_WIDTH-1:0] addr;
        thread_id_t                 id;
        logic [31:0]                due;
    } pending_t;

    pending_t    pending [$];
    pending_t    entry;
    int unsigned rng;
    logic [31:0] cycle;

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // answers come back in order on one channel, each after its own random delay
    always @(posedge aclk) begin
        if (!rst_n) begin
            pending.delete();
            rng     = SEED;
            cycle   = '0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rid     <= '0;
        end else begin
            cycle = cycle + 32'd1;
            if (arvalid && arready) begin
                rng        = lcg_next(rng);
                entry.addr = araddr;
                entry.id   = arid;
                // each channel looks at a different slice of the generator
                entry.due  = cycle + ((rng >> (16 + 4 * CH)) % 32'd16);
                pending.push_back(entry);
            end
            if (!rvalid || rready) begin
                if (pending.size() != 0 && pending[0].due <= cycle) begin
                    entry  = pending.pop_front();
                    rdata  <= `ECI_CL_WIDTH'({LINE_REPS{entry.addr}});
                    rid    <= entry.id;
                    rvalid <= 1'b1;
                end else begin
                    rvalid <= 1'b0;
                end
            end
            arready <= (pending.size() < MAX_PENDING);
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_reorder_rd.sv
`timescale 1ns/100ps
`default_nettype none

`include "reorder_params.svh"

module tb_reorder_rd;

    import reorder_pkg::*;

    localparam int          CLK_HALF        = 4;
    localparam int          RESET_CYCLES    = 3;
    localparam int          N_BURSTS        = 24;
    localparam int          CYCLES_PER_LINE = 200;
    localparam int unsigned LCG_SEED        = 60790;
    localparam int          LINE_REPS = (`ECI_CL_WIDTH + `ECI_ADDR_WIDTH - 1) / `ECI_ADDR_WIDTH;

    logic                            aclk = 1'b0;
    logic                            rst_n;
    rd_burst_t                       ar_burst;
    logic                            ar_valid;
    wire                             ar_ready;
    wire rd_rsp_t                    r_rsp;
    wire                             r_valid;
    logic                            r_ready = 1'b0;
    wire  [1:0][`ECI_ADDR_WIDTH-1:0] ch_araddr;
    wire thread_id_t [1:0]           ch_arid;
    wire  [1:0]                      ch_arvalid;
    wire  [1:0]                      ch_arready;
    wire  [1:0][`ECI_CL_WIDTH-1:0]   ch_rdata;
    wire thread_id_t [1:0]           ch_rid;
    wire  [1:0]                      ch_rvalid;
    wire  [1:0]                      ch_rready;

    rd_line_t                   exp_q [$];
    logic [`N_THREADS-1:0]      ids_out;
    logic [`ECI_ADDR_WIDTH-1:0] burst_addr [2*N_BURSTS];
    int                         burst_len  [2*N_BURSTS];
    int unsigned                ready_rng = LCG_SEED;
    logic                       random_ready;
    string                      test_name;
    int                         test_count;
    int                         err_reset  = 0;
    int                         err_beat   = 0;
    int                         err_chan   = 0;
    int                         err_stable = 0;

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int total_errors();
        return err_reset + err_beat + err_chan + err_stable;
    endfunction

    eci_reorder_rd_2vc i_eci_reorder_rd_2vc (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .ar_burst  (ar_burst),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .r_rsp     (r_rsp),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .ch_araddr (ch_araddr),
        .ch_arid   (ch_arid),
        .ch_arvalid(ch_arvalid),
        .ch_arready(ch_arready),
        .ch_rdata  (ch_rdata),
        .ch_rid    (ch_rid),
        .ch_rvalid (ch_rvalid),
        .ch_rready (ch_rready)
    );

    for (genvar c = 0; c < 2; c++) begin : g_mem
        tb_mem_channel #(
            .SEED(LCG_SEED),
            .CH  (c)
        ) i_mem_channel (
            .aclk   (aclk),
            .rst_n  (rst_n),
            .araddr (ch_araddr[c]),
            .arid   (ch_arid[c]),
            .arvalid(ch_arvalid[c]),
            .arready(ch_arready[c]),
            .rdata  (ch_rdata[c]),
            .rid    (ch_rid[c]),
            .rvalid (ch_rvalid[c]),
            .rready (ch_rready[c])
        );
    end

    always #CLK_HALF aclk = ~aclk;

    always @(posedge aclk) begin
        ready_rng = lcg_next(ready_rng);
        r_ready  <= random_ready ? ready_rng[16] : 1'b1;
    end

    // expected beats are built from the bursts that the DUT actually accepted
    always @(posedge aclk) begin
        rd_line_t                 beat;
        logic [`ECI_CL_WIDTH-1:0] exp_data;
        if (rst_n && r_valid && r_ready) begin
            if (exp_q.size() == 0) begin
                $display("%s: read beat returned with no line outstanding", test_name);
                err_beat++;
            end else begin
                beat     = exp_q.pop_front();
                exp_data = `ECI_CL_WIDTH'({LINE_REPS{beat.addr}});
                assert (r_rsp.rdata == exp_data) else begin
                    $display("ERR %s rdata expected %h actual %h", test_name, exp_data,
                             r_rsp.rdata);
                    err_beat++;
                end
                assert (r_rsp.rlast == beat.last) else begin
                    $display("ERR %s rlast expected %b actual %b", test_name, beat.last,
                             r_rsp.rlast);
                    err_beat++;
                end
                assert (r_rsp.rresp == 2'b00) else begin
                    $display("ERR %s rresp expected %b actual %b", test_name, 2'b00,
                             r_rsp.rresp);
                    err_beat++;
                end
            end
        end
        if (rst_n && ar_valid && ar_ready) begin
            for (int i = 0; i <= int'(ar_burst.arlen); i++) begin
                beat.addr = ar_burst.araddr + `ECI_ADDR_WIDTH'(i * `ECI_CL_BYTES);
                beat.last = (i == int'(ar_burst.arlen));
                exp_q.push_back(beat);
            end
        end
    end

    // an ID counts as outstanding from its channel request until its response
    always @(posedge aclk) begin
        if (!rst_n) begin
            ids_out = '0;
        end else begin
            for (int c = 0; c < 2; c++) begin
                assert (!ch_rvalid[c] || ch_rready[c]) else begin
                    $display("%s: channel %0d response was not accepted", test_name, c);
                    err_chan++;
                end
                if (ch_rvalid[c] && ch_rready[c]) begin
                    ids_out[ch_rid[c]] = 1'b0;
                end
            end
            for (int c = 0; c < 2; c++) begin
                if (ch_arvalid[c]) begin
                    assert (ch_araddr[c][`VC_SEL_BIT] == 1'(c)) else begin
                        $display("ERR %s channel %0d address bit expected %0d actual %0d",
                                 test_name, c, c, ch_araddr[c][`VC_SEL_BIT]);
                        err_chan++;
                    end
                end
                if (ch_arvalid[c] && ch_arready[c]) begin
                    assert (!ids_out[ch_arid[c]]) else begin
                        $display("%s: channel %0d reused thread ID %0d while outstanding",
                                 test_name, c, ch_arid[c]);
                        err_chan++;
                    end
                    ids_out[ch_arid[c]] = 1'b1;
                end
            end
        end
    end

    a_r_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        (r_valid && !r_ready) |=> (r_valid && $stable(r_rsp.rdata) && $stable(r_rsp.rlast)))
        else begin
            $display("%s: read response changed while stalled", test_name);
            err_stable++;
        end

    task automatic watchdog(input int cycles);
        repeat (cycles) @(posedge aclk);
        $display("timeout: read data did not complete within %0d cycles", cycles);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    task automatic issue_burst(input logic [`ECI_ADDR_WIDTH-1:0] addr, input int lines);
        ar_burst.araddr <= addr;
        ar_burst.arlen  <= 8'(lines - 1);
        ar_valid        <= 1'b1;
        @(posedge aclk);
        while (!ar_ready) begin
            @(posedge aclk);
        end
        ar_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        @(posedge aclk);
        while (exp_q.size() != 0) begin
            @(posedge aclk);
        end
        repeat (4) @(posedge aclk);
    endtask

    task automatic report_test(input int errs_before);
        test_count++;
        $display("test %s %s, %0d errors", test_name,
                 (total_errors() == errs_before) ? "ok" : "bad", total_errors() - errs_before);
    endtask

    initial begin
        int unsigned burst_rng;
        int          total_lines;
        int          errs_before;
        burst_rng    = LCG_SEED;
        rst_n        = 1'b0;
        ar_valid     = 1'b0;
        ar_burst     = '0;
        random_ready = 1'b0;
        test_count   = 0;
        total_lines  = 1;
        for (int b = 0; b < 2 * N_BURSTS; b++) begin
            burst_rng     = lcg_next(burst_rng);
            burst_len[b]  = 1 + int'((burst_rng >> 16) % 8);
            burst_rng     = lcg_next(burst_rng);
            burst_addr[b] = `ECI_ADDR_WIDTH'({burst_rng, 7'd0});
            total_lines  += burst_len[b];
        end
        fork
            watchdog(total_lines * CYCLES_PER_LINE);
        join_none

        test_name   = "reset_state";
        errs_before = total_errors();
        repeat (RESET_CYCLES) @(posedge aclk);
        rst_n <= 1'b1;
        @(posedge aclk);
        assert (ar_ready === 1'b1 && ch_arvalid === 2'b00 && r_valid === 1'b0) else begin
            $display("ERR %s expected ar_ready=1 arvalid=00 r_valid=0 actual %b %b %b",
                     test_name, ar_ready, ch_arvalid, r_valid);
            err_reset++;
        end
        report_test(errs_before);

        test_name   = "single_line";
        errs_before = total_errors();
        issue_burst(`ECI_ADDR_WIDTH'('h1000), 1);
        wait_drain();
        report_test(errs_before);

        test_name   = "random_bursts";
        errs_before = total_errors();
        for (int b = 0; b < N_BURSTS; b++) begin
            issue_burst(burst_addr[b], burst_len[b]);
        end
        wait_drain();
        report_test(errs_before);

        // r_ready now toggles, so the stall and reorder paths both get exercised
        test_name    = "backpressure";
        errs_before  = total_errors();
        random_ready <= 1'b1;
        for (int b = N_BURSTS; b < 2 * N_BURSTS; b++) begin
            issue_burst(burst_addr[b], burst_len[b]);
        end
        wait_drain();
        random_ready <= 1'b0;
        report_test(errs_before);

        $display("tests run: %0d, errors: %0d", test_count, total_errors());
        if (total_errors() == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+hdl
hdl/reorder_pkg.sv
hdl/stage_fifo.sv
hdl/rd_burst_split.sv
hdl/rd_vc_dispatch.sv
hdl/rd_reorder_buffer.sv
hdl/eci_reorder_rd_2vc.sv
testbench/tb_mem_channel.sv
testbench/tb_reorder_rd.sv

//--- Makefile
TOP = tb_reorder_rd
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f all.f --top-module $(TOP) \
		-Mdir $(OBJ) -o V$(TOP)

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf $(OBJ) sim.log
